/* src/link_settings.svh */
// link-wide constants (framing word, length width, CRC-16 parameters), include where a module needs them
`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// ---------------------------------------------------------------------------
// framing
// ---------------------------------------------------------------------------

// marks the start of every packet on the line
`define LINK_MAGIC 32'hAC450F28

// header length field, counts data quadlets
`define LINK_LEN_W 10

// ---------------------------------------------------------------------------
// CRC-16/CCITT
// ---------------------------------------------------------------------------

// msb-first, no reflection, no final xor
`define LINK_CRC_POLY 16'h1021
`define LINK_CRC_INIT 16'hFFFF

`endif

/* src/link_frame_pkg.sv */
// wire-format quadlet layouts of the serial link, used by the transmitter and receiver
`include "link_settings.svh"

package link_frame_pkg;

    // ------------------------------------------------------------------------
    // header quadlet, second word on the line after the magic
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0]              page;  // bits 31..16
        logic [15-`LINK_LEN_W:0]  zero;  // unused, sent as zero
        logic [`LINK_LEN_W-1:0]   len;   // data quadlet count
    } link_hdr_t;

    // ------------------------------------------------------------------------
    // trailer quadlet, last word of a packet
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0] zero;               // unused, sent as zero
        logic [15:0] crc;                // over header and data bytes
    } link_trailer_t;

    // one received quadlet; the receiver reads it as a header or a trailer
    // depending on where it is in the packet
    typedef union packed {
        logic [31:0]   raw;
        link_hdr_t     hdr;
        link_trailer_t trl;
    } link_quad_u;

endpackage

/* src/link_stream_pkg.sv */
// parallel-side beat types of the serial link streams, used by the link ports and the testbench
`include "link_settings.svh"

package link_stream_pkg;

    // ------------------------------------------------------------------------
    // header beat, on tx_hdr and rx_hdr
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0]            page;
        logic [`LINK_LEN_W-1:0] len;    // number of data words that follow
    } hdr_beat_t;

    // ------------------------------------------------------------------------
    // received data word with its position in the packet
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [31:0]            data;
        logic [`LINK_LEN_W-1:0] index;  // 0 for the first word after the header
    } word_beat_t;

    // ------------------------------------------------------------------------
    // end of packet report
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic        crc_good;          // trailer matched the local crc
        logic [15:0] crc_rx;            // value found in the trailer
        logic [15:0] crc_calc;          // value computed over the packet
    } rx_status_t;

endpackage

/* src/crc16_byte.sv */
// byte-wise CRC-16 engine, one byte folded per enabled clock, shared by transmitter and receiver
`timescale 1ns/1ps
`include "link_settings.svh"

module crc16_byte (
    input  logic        clock,
    input  logic        reset,
    input  logic        init,   // reload the initial value, wins over ena
    input  logic        ena,    // fold data this cycle
    input  logic [7:0]  data,
    output logic [15:0] crc
);

    logic [15:0] crc_next;

    // eight serial steps unrolled, msb of the byte first
    always_comb begin
        logic fb;
        crc_next = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = crc_next[15] ^ data[i];
            crc_next = {crc_next[14:0], 1'b0};
            if (fb) begin
                crc_next = crc_next ^ `LINK_CRC_POLY;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || init) begin
            crc <= `LINK_CRC_INIT;
        end else if (ena) begin
            crc <= crc_next;
        end
    end

endmodule

/* src/link_tx.sv */
// packet serializer, sends magic, header, data words and CRC trailer lsb first on one line
`timescale 1ns/1ps
`include "link_settings.svh"

module link_tx (
    input  logic                       clock,
    input  logic                       reset,
    input  link_stream_pkg::hdr_beat_t tx_hdr,
    input  logic                       tx_hdr_valid,
    output logic                       tx_hdr_ready,
    input  logic [31:0]                tx_word,
    input  logic                       tx_word_valid,
    output logic                       tx_word_ready,
    output logic                       tx_underrun,
    output logic                       tx_line
);

    typedef enum logic [1:0] {S_FRAME, S_HDR, S_DATA, S_TRL} tx_state_t;

    tx_state_t                  state;
    logic [4:0]                 bit_cnt;    // bit of quad going out next
    logic [`LINK_LEN_W-1:0]     word_cnt;   // index of the data quadlet in flight
    logic                       framing;    // S_FRAME quad is the magic, else idle
    logic [31:0]                quad;       // quadlet being serialized
    link_stream_pkg::hdr_beat_t hdr_q;      // header of the current packet
    logic [31:0]                word_buf;   // word fetched for the next quadlet
    logic                       have_word;

    logic                          quad_end;
    logic                          hdr_take;
    logic                          word_take;
    logic                          want_word;
    logic                          last_word;
    logic                          starved;
    logic [31:0]                   data_word;
    link_frame_pkg::link_hdr_t     hdr_word;
    link_frame_pkg::link_trailer_t trl_word;
    logic                          crc_ena;
    logic [7:0]                    crc_byte;
    logic [15:0]                   crc;

    // ------------------------------------------------------------------------
    // stream handshakes
    // ------------------------------------------------------------------------
    assign quad_end  = (bit_cnt == 5'd31);
    assign last_word = (word_cnt == hdr_q.len - `LINK_LEN_W'(1));

    // a header can only slip in where idle or a trailer ends
    assign tx_hdr_ready = quad_end && tx_hdr_valid &&
                          ((state == S_FRAME && !framing) || state == S_TRL);
    assign hdr_take     = tx_hdr_valid && tx_hdr_ready;

    // the quadlet after this one is data
    assign want_word     = (state == S_HDR && hdr_q.len != '0) ||
                           (state == S_DATA && !last_word);
    assign tx_word_ready = want_word && !have_word;
    assign word_take     = tx_word_valid && tx_word_ready;
    assign starved       = quad_end && want_word && !have_word && !word_take;

    // late word goes straight through, a missing one becomes zero
    assign data_word = have_word ? word_buf : (word_take ? tx_word : 32'd0);

    always_comb begin
        hdr_word      = '0;
        hdr_word.page = hdr_q.page;
        hdr_word.len  = hdr_q.len;
        trl_word      = '0;
        trl_word.crc  = crc;
    end

    // ------------------------------------------------------------------------
    // quadlet sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= S_FRAME;
            bit_cnt     <= '0;
            word_cnt    <= '0;
            framing     <= 1'b0;
            quad        <= '0;
            have_word   <= 1'b0;
            tx_underrun <= 1'b0;
            tx_line     <= 1'b0;
        end else begin
            bit_cnt     <= bit_cnt + 5'd1;
            tx_line     <= quad[bit_cnt];
            tx_underrun <= starved;
            if (word_take) begin
                have_word <= 1'b1;
            end
            if (quad_end) begin
                have_word <= 1'b0;                  // buffered word used below
                case (state)
                    S_FRAME: begin
                        if (framing) begin
                            state   <= S_HDR;
                            quad    <= hdr_word;
                            framing <= 1'b0;
                        end else if (hdr_take) begin
                            quad    <= `LINK_MAGIC;
                            framing <= 1'b1;
                        end else begin
                            quad    <= '0;
                        end
                    end
                    S_HDR: begin
                        word_cnt <= '0;
                        if (hdr_q.len == '0) begin
                            state <= S_TRL;             // empty packet
                            quad  <= trl_word;
                        end else begin
                            state <= S_DATA;
                            quad  <= data_word;
                        end
                    end
                    S_DATA: begin
                        if (last_word) begin
                            state <= S_TRL;
                            quad  <= trl_word;
                        end else begin
                            word_cnt <= word_cnt + `LINK_LEN_W'(1);
                            quad     <= data_word;
                        end
                    end
                    default: begin                      // S_TRL
                        state   <= S_FRAME;
                        quad    <= hdr_take ? `LINK_MAGIC : 32'd0;
                        framing <= hdr_take;            // back-to-back packet
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hdr_take) begin
            hdr_q <= tx_hdr;
        end
        if (word_take) begin
            word_buf <= tx_word;
        end
    end

    // ------------------------------------------------------------------------
    // crc over header and data, one byte in each of the first four bit cycles
    // ------------------------------------------------------------------------
    assign crc_ena  = (state == S_HDR || state == S_DATA) && (bit_cnt[4:2] == 3'd0);
    assign crc_byte = quad[{bit_cnt[1:0], 3'b000} +: 8];   // lsb byte first

    crc16_byte u_crc (
        .clock (clock),
        .reset (reset),
        .init  (state == S_FRAME),
        .ena   (crc_ena),
        .data  (crc_byte),
        .crc   (crc)
    );

endmodule

/* src/link_rx.sv */
// packet deserializer, hunts for the magic and delivers header, data words and CRC status
`timescale 1ns/1ps
`include "link_settings.svh"

module link_rx (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         rx_line,
    output link_stream_pkg::hdr_beat_t   rx_hdr,
    output logic                         rx_hdr_valid,
    output link_stream_pkg::word_beat_t  rx_word,
    output logic                         rx_word_valid,
    output link_stream_pkg::rx_status_t  rx_status,
    output logic                         rx_eop
);

    typedef enum logic [1:0] {S_HUNT, S_HDR, S_DATA, S_TRL} rx_state_t;

    rx_state_t                  state;
    link_frame_pkg::link_quad_u sr;         // lsb first, full word at bit_cnt 31
    logic [4:0]                 bit_cnt;    // bits of the quadlet in sr, minus one
    logic [`LINK_LEN_W-1:0]     word_cnt;
    logic [`LINK_LEN_W-1:0]     len_q;      // data quadlets still expected in total

    logic        quad_full;
    logic        crc_ena;
    logic [15:0] crc;

    assign quad_full = (bit_cnt == 5'd31);

    // ------------------------------------------------------------------------
    // line shift register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            sr.raw <= '0;
        end else begin
            sr.raw <= {rx_line, sr.raw[31:1]};
        end
    end

    // ------------------------------------------------------------------------
    // packet FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= S_HUNT;
            bit_cnt       <= '0;
            word_cnt      <= '0;
            rx_hdr_valid  <= 1'b0;
            rx_word_valid <= 1'b0;
            rx_eop        <= 1'b0;
        end else begin
            bit_cnt       <= bit_cnt + 5'd1;
            rx_hdr_valid  <= 1'b0;
            rx_word_valid <= 1'b0;
            rx_eop        <= 1'b0;
            case (state)
                S_HUNT: begin
                    if (sr.raw == `LINK_MAGIC) begin
                        state   <= S_HDR;
                        bit_cnt <= '0;              // header bit 0 arrives now
                    end
                end
                S_HDR: begin
                    if (quad_full) begin
                        rx_hdr_valid <= 1'b1;
                        word_cnt     <= '0;
                        state        <= (sr.hdr.len == '0) ? S_TRL : S_DATA;
                    end
                end
                S_DATA: begin
                    if (quad_full) begin
                        rx_word_valid <= 1'b1;
                        if (word_cnt == len_q - `LINK_LEN_W'(1)) begin
                            state <= S_TRL;
                        end else begin
                            word_cnt <= word_cnt + `LINK_LEN_W'(1);
                        end
                    end
                end
                default: begin                          // S_TRL
                    if (quad_full) begin
                        rx_eop <= 1'b1;
                        state  <= S_HUNT;
                    end
                end
            endcase
        end
    end

    // output payload, qualified by the valid pulses above
    always_ff @(posedge clock) begin
        if (state == S_HDR && quad_full) begin
            len_q       <= sr.hdr.len;
            rx_hdr.page <= sr.hdr.page;
            rx_hdr.len  <= sr.hdr.len;
        end
        if (state == S_DATA && quad_full) begin
            rx_word.data  <= sr.raw;
            rx_word.index <= word_cnt;
        end
        if (state == S_TRL && quad_full) begin
            rx_status.crc_good <= (sr.trl.crc == crc);
            rx_status.crc_rx   <= sr.trl.crc;
            rx_status.crc_calc <= crc;
        end
    end

    // ------------------------------------------------------------------------
    // crc check, each byte sits in sr[31:24] right after its eighth bit
    // ------------------------------------------------------------------------
    assign crc_ena = (state == S_HDR || state == S_DATA) && (bit_cnt[2:0] == 3'd7);

    crc16_byte u_crc (
        .clock (clock),
        .reset (reset),
        .init  (state == S_HUNT),
        .ena   (crc_ena),
        .data  (sr.raw[31:24]),
        .crc   (crc)
    );

endmodule

/* src/serial_link_top.sv */
// serial link subsystem, one transmitter and one receiver with separate lines for board-to-board use
`timescale 1ns/1ps

module serial_link_top (
    input  logic                         clock,
    input  logic                         reset,

    // transmit side
    input  link_stream_pkg::hdr_beat_t   tx_hdr,
    input  logic                         tx_hdr_valid,
    output logic                         tx_hdr_ready,
    input  logic [31:0]                  tx_word,
    input  logic                         tx_word_valid,
    output logic                         tx_word_ready,
    output logic                         tx_underrun,
    output logic                         tx_line,

    // receive side
    input  logic                         rx_line,
    output link_stream_pkg::hdr_beat_t   rx_hdr,
    output logic                         rx_hdr_valid,
    output link_stream_pkg::word_beat_t  rx_word,
    output logic                         rx_word_valid,
    output link_stream_pkg::rx_status_t  rx_status,
    output logic                         rx_eop
);

    // ------------------------------------------------------------------------
    // the two directions share only clock and reset
    // ------------------------------------------------------------------------
    link_tx u_tx (
        .clock         (clock),
        .reset         (reset),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid),
        .tx_word_ready (tx_word_ready),
        .tx_underrun   (tx_underrun),
        .tx_line       (tx_line)
    );

    link_rx u_rx (
        .clock         (clock),
        .reset         (reset),
        .rx_line       (rx_line),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .rx_status     (rx_status),
        .rx_eop        (rx_eop)
    );

endmodule

/* tb/tb_serial_link.sv */
// loopback testbench for serial_link_top that replays tb/link_trace.txt and checks every receive beat
`timescale 1ns/1ps
`include "link_settings.svh"

module tb_serial_link;

    localparam int TIMEOUT = 4000;                      // cycles allowed for any one wait
    localparam int NONE    = 'hFFF;                     // trace mark meaning no mark

    logic clock = 1'b0;
    logic reset = 1'b1;
    link_stream_pkg::hdr_beat_t  tx_hdr, rx_hdr;
    link_stream_pkg::word_beat_t rx_word;
    link_stream_pkg::rx_status_t rx_status;
    logic        tx_hdr_valid, tx_hdr_ready, tx_word_valid, tx_word_ready;
    logic        tx_underrun, tx_line, rx_line, rx_hdr_valid, rx_word_valid, rx_eop;
    logic [31:0] tx_word;
    logic        inj = 1'b0;                            // flips the bit now on the line

    int pk_page[$], pk_len[$], pk_fw[$], pk_fb[$], pk_sw[$], pk_base[$];
    logic [31:0] words[$];
    link_stream_pkg::hdr_beat_t  exp_hdr[$];
    link_stream_pkg::word_beat_t exp_word[$];
    link_stream_pkg::rx_status_t exp_stat[$];
    int   uflow_exp = 0, uflow_seen = 0, eop_seen = 0;
    logic hdr_offered = 1'b0;
    logic [15:0] lfsr = 16'd64;

    always #4 clock = ~clock;

    assign rx_line = tx_line ^ inj;                     // loopback with error injection

    serial_link_top u_dut (.*);

    // ------------------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic report_fail();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        report_fail();
    endtask

    task automatic check_hdr(input string name, input link_stream_pkg::hdr_beat_t exp,
                             input link_stream_pkg::hdr_beat_t act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected page=%h len=%0d got page=%h len=%0d",
                     $time, name, exp.page, exp.len, act.page, act.len);
            report_fail();
        end
    endtask

    task automatic check_word(input string name, input link_stream_pkg::word_beat_t exp,
                              input link_stream_pkg::word_beat_t act);
        if (act !== exp) begin
            $display("CHECK FAILED time=%0t %s expected data=%h index=%0d got data=%h index=%0d",
                     $time, name, exp.data, exp.index, act.data, act.index);
            report_fail();
        end
    endtask

    task automatic check_status(input string name, input link_stream_pkg::rx_status_t exp,
                                input link_stream_pkg::rx_status_t act);
        if (act !== exp) begin
            $display(
                "CHECK FAILED time=%0t %s expected ok=%b rx=%h calc=%h got ok=%b rx=%h calc=%h",
                $time, name, exp.crc_good, exp.crc_rx, exp.crc_calc,
                act.crc_good, act.crc_rx, act.crc_calc);
            report_fail();
        end
    endtask

    // ------------------------------------------------------------------------
    // reference CRC and random gaps
    // ------------------------------------------------------------------------
    function automatic logic [15:0] crc_quad(input logic [15:0] c, input logic [31:0] q);
        for (int b = 0; b < 4; b++) begin               // lsb byte first and msb bit first
            for (int i = 7; i >= 0; i--) begin
                if (c[15] ^ q[8*b+i]) c = {c[14:0], 1'b0} ^ `LINK_CRC_POLY;
                else c = {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_wait();
        int n;
        n = 0;
        for (int i = 0; i < 4; i++) begin               // one step per bit taken
            n = (n << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        repeat (n) @(negedge clock);
    endtask

    // ------------------------------------------------------------------------
    // trace loading and expected values built from the trace
    // ------------------------------------------------------------------------
    task automatic load_trace();
        int fd, n, a, b, c, d, e;
        string line;
        fd = $fopen("tb/link_trace.txt", "r");
        if (fd == 0) stop_run("cannot open tb/link_trace.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0) continue;
            if (line[0] == "P") begin
                n = $sscanf(line, "P %h %h %h %h %h", a, b, c, d, e);
                pk_page.push_back(a);
                pk_len.push_back(b);
                pk_fw.push_back(c);
                pk_fb.push_back(d);
                pk_sw.push_back(e);
                pk_base.push_back(words.size());
            end else if (line[0] == "W") begin
                n = $sscanf(line, "W %h", a);
                words.push_back(a);
            end
        end
        $fclose(fd);
    endtask

    task automatic build_expected();
        link_stream_pkg::hdr_beat_t  h;
        link_stream_pkg::word_beat_t wb;
        link_stream_pkg::rx_status_t st;
        logic [15:0] crc_t, crc_r;
        logic [31:0] sent, got;
        for (int p = 0; p < pk_page.size(); p++) begin
            h.page = pk_page[p];
            h.len  = pk_len[p];
            exp_hdr.push_back(h);
            crc_t = crc_quad(`LINK_CRC_INIT, {h.page, 6'd0, h.len});
            crc_r = crc_t;
            for (int k = 0; k < pk_len[p]; k++) begin
                sent = (k == pk_sw[p]) ? 32'd0 : words[pk_base[p] + k];
                got  = (k == pk_fw[p]) ? sent ^ (32'd1 << pk_fb[p]) : sent;
                crc_t = crc_quad(crc_t, sent);
                crc_r = crc_quad(crc_r, got);
                wb.data  = got;
                wb.index = k;
                exp_word.push_back(wb);
                if (k == pk_sw[p]) uflow_exp++;
            end
            st.crc_good = (pk_fw[p] == NONE);           // only a flipped bit breaks the crc
            st.crc_rx   = crc_t;
            st.crc_calc = crc_r;
            exp_stat.push_back(st);
        end
    endtask

    // ------------------------------------------------------------------------
    // stream drivers called on a falling edge
    // ------------------------------------------------------------------------
    task automatic send_hdr(input link_stream_pkg::hdr_beat_t h);
        int t;
        random_wait();
        hdr_offered  = 1'b1;
        tx_hdr       = h;
        tx_hdr_valid = 1'b1;
        #1;
        t = 0;
        while (!tx_hdr_ready) begin
            @(negedge clock);
            #1;
            t++;
            if (t > TIMEOUT) stop_run("header was never accepted");
        end
        @(negedge clock);                               // transfer at the edge in between
        tx_hdr_valid = 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        int t;
        random_wait();
        tx_word       = w;
        tx_word_valid = 1'b1;
        #1;
        t = 0;
        while (!tx_word_ready) begin
            @(negedge clock);
            #1;
            t++;
            if (t > TIMEOUT) stop_run("data word was never accepted");
        end
        @(negedge clock);
        tx_word_valid = 1'b0;
    endtask

    task automatic wait_underrun();
        int t;
        t = 0;
        while (!tx_underrun) begin
            @(negedge clock);
            t++;
            if (t > TIMEOUT) stop_run("withheld word gave no underrun pulse");
        end
    endtask

    // ------------------------------------------------------------------------
    // transmit line tracker that sets inj for the marked bit
    // ------------------------------------------------------------------------
    logic [31:0] tx_sr = '0;
    logic        tracking = 1'b0;
    int          bit_no, pk_bits, flip_at, tx_pkt = 0;

    always @(negedge clock) begin
        tx_sr = {tx_line, tx_sr[31:1]};
        inj   = 1'b0;
        if (reset) begin
            tracking = 1'b0;
        end else if (tracking) begin
            if (bit_no == flip_at) inj = 1'b1;
            bit_no++;
            if (bit_no == pk_bits) tracking = 1'b0;
        end else if (tx_sr == `LINK_MAGIC && tx_pkt < pk_len.size()) begin
            tracking = 1'b1;                            // header bit 0 shows next
            bit_no   = 0;
            pk_bits  = 32 * (pk_len[tx_pkt] + 2);
            flip_at  = (pk_fw[tx_pkt] == NONE) ? -1 : 32 * (pk_fw[tx_pkt] + 1) + pk_fb[tx_pkt];
            tx_pkt++;
        end
    end

    // ------------------------------------------------------------------------
    // receive monitor
    // ------------------------------------------------------------------------
    always @(negedge clock) begin
        if (!reset) begin
            if (!hdr_offered && (tx_hdr_ready || tx_word_ready || rx_hdr_valid ||
                                 rx_word_valid || rx_eop))
                stop_run("handshake or receive pulse before any header was offered");
            if (tx_underrun) uflow_seen++;
            if (rx_hdr_valid) begin
                if (exp_hdr.size() == 0) stop_run("unexpected rx_hdr_valid");
                check_hdr("rx_hdr", exp_hdr.pop_front(), rx_hdr);
            end
            if (rx_word_valid) begin
                if (exp_word.size() == 0) stop_run("unexpected rx_word_valid");
                check_word("rx_word", exp_word.pop_front(), rx_word);
            end
            if (rx_eop) begin
                if (exp_stat.size() == 0) stop_run("unexpected rx_eop");
                check_status("rx_status", exp_stat.pop_front(), rx_status);
                eop_seen++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        link_stream_pkg::hdr_beat_t h;
        int t;
        tx_hdr        = '0;
        tx_hdr_valid  = 1'b0;
        tx_word       = '0;
        tx_word_valid = 1'b0;
        load_trace();
        build_expected();
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (80) @(negedge clock);                   // idle quadlets only
        for (int p = 0; p < pk_page.size(); p++) begin
            h.page = pk_page[p];
            h.len  = pk_len[p];
            send_hdr(h);
            for (int k = 0; k < pk_len[p]; k++) begin
                if (k == pk_sw[p]) wait_underrun();
                else send_word(words[pk_base[p] + k]);
            end
        end
        t = 0;
        while (eop_seen < pk_page.size()) begin
            @(negedge clock);
            t++;
            if (t > TIMEOUT) stop_run("missing end of packet pulses");
        end
        repeat (100) @(negedge clock);                  // catch stray pulses
        if (eop_seen == pk_page.size() && uflow_seen == uflow_exp &&
            exp_hdr.size() == 0 && exp_word.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("ERROR eop %0d of %0d, underruns %0d of %0d, beats left %0d",
                     eop_seen, pk_page.size(), uflow_seen, uflow_exp,
                     exp_hdr.size() + exp_word.size());
            report_fail();
        end
    end

endmodule

/* tb/link_trace.txt */
# P page len flip_word flip_bit withheld_word   (hex, FFF = no mark)
# W data word, one line per word of the packet above
P 1234 3 FFF 0 FFF
W 00000001
W DEADBEEF
W 80000000
P 0042 0 FFF 0 FFF
P BEEF 2 001 5 FFF
W 11223344
W 55667788
P 0007 1 FFF 0 FFF
W CAFEF00D
P 00A5 4 FFF 0 002
W 0F0F0F0F
W F0F0F0F0
W 12345678
W 9ABCDEF0
P 5A5A 2 FFF 0 FFF
W FFFFFFFF
W 00000000
P 0100 1 000 1F FFF
W 76543210
P FFFF 5 FFF 0 FFF
W A5A5A5A5
W 5A5A5A5A
W 01020304
W 05060708
W 090A0B0C
P 0003 0 FFF 0 FFF
P 2222 2 FFF 0 000
W 13579BDF
W 2468ACE0

/* filelist.f */
+incdir+src
src/link_frame_pkg.sv
src/link_stream_pkg.sv
src/crc16_byte.sv
src/link_tx.sv
src/link_rx.sv
src/serial_link_top.sv
tb/tb_serial_link.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_serial_link
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
